/* src/bus_pkg.sv */
package bus_pkg;

    // processor bus widths
    localparam int addr_w = 64;
    localparam int data_w = 64;

    // load/store type as the core sends it
    // bits 1:0 give the access size
    // bit 2 marks an unsigned load, ignored here since loads come back zero-extended
    typedef logic [2:0] ls_type_t;

    // size codes, low two bits of ls_type_t
    localparam logic [1:0] ls_byte   = 2'b00;
    localparam logic [1:0] ls_half   = 2'b01;
    localparam logic [1:0] ls_word   = 2'b10;
    // doubleword, two memory words
    localparam logic [1:0] ls_double = 2'b11;

    // one 32-bit memory word, little endian
    // byte 0 and half 0 sit in the low bits
    // the memory picks load lanes and merges stores through it
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } ram_word_t;

endpackage

/* src/soc_map_pkg.sv */
package soc_map_pkg;

    // data memory window
    // length is four bytes per word of the ram_words depth
    localparam logic [bus_pkg::addr_w-1:0] ram_base = 64'h0000_0000_0001_0000;

    // io registers, well above the memory window
    // last key code, read only
    localparam logic [bus_pkg::addr_w-1:0] key_addr = 64'h0000_0000_0002_0000;

    // console byte port, write only
    localparam logic [bus_pkg::addr_w-1:0] console_addr = 64'h0000_0000_0002_0008;

    // interrupt vector codes
    // zero means no request pending
    localparam logic [3:0] irq_key = 4'd1;

endpackage

/* src/data_ram.sv */
module data_ram #(
    parameter int ram_words = 3072
) (
    input  logic                       CLOCK_50,
    input  logic                       KEY0,
    input  logic [bus_pkg::addr_w-1:0] bus_address,
    input  logic [bus_pkg::data_w-1:0] bus_write_data,
    input  bus_pkg::ls_type_t          bus_ls_type,
    input  logic                       read_active,
    input  logic                       write_active,
    output logic                       ram_hit,
    output logic                       ram_read_ack,
    output logic                       ram_write_ack,
    output logic [bus_pkg::data_w-1:0] ram_rdata
);

    localparam int aw    = bus_pkg::addr_w;
    localparam int idx_w = $clog2(ram_words);
    // window length in bytes
    localparam logic [aw-1:0] ram_bytes = aw'(ram_words) << 2;

    // block ram, one read and one write port
    bus_pkg::ram_word_t mem [ram_words];

    logic [aw-1:0]              offset;
    logic [idx_w-1:0]           word_idx;
    logic [idx_w-1:0]           rd_idx;
    logic [idx_w-1:0]           wr_idx;
    logic [1:0]                 size;
    logic [1:0]                 lane;
    logic                       is_double;
    logic                       go_rd;
    logic                       go_wr;
    // a word read went out last cycle and rd_q now holds it
    logic                       pend;
    // second word of a doubleword
    logic                       step;
    bus_pkg::ram_word_t         rd_q;
    bus_pkg::ram_word_t         wr_word;
    logic [bus_pkg::data_w-1:0] load_data;

    // below the base wraps to a huge offset and misses
    assign offset   = bus_address - soc_map_pkg::ram_base;
    assign ram_hit  = offset < ram_bytes;
    assign word_idx = offset[idx_w+1:2];

    assign size      = bus_ls_type[1:0];
    assign lane      = bus_address[1:0];
    assign is_double = size == bus_pkg::ls_double;

    // act only inside the window and until our own ack
    assign go_rd = read_active && ram_hit && !ram_read_ack;
    assign go_wr = write_active && ram_hit && !ram_write_ack;

    // doubleword reads issue the high word while the low one returns
    assign rd_idx = word_idx + idx_w'(pend & is_double);
    // doubleword writes put the high word one word up
    assign wr_idx = word_idx + idx_w'(step);

    // store merge into the old word
    always_comb begin
        wr_word = rd_q;
        case (size)
            bus_pkg::ls_byte: wr_word.bytes[lane] = bus_write_data[7:0];
            bus_pkg::ls_half: wr_word.halves[lane[1]] = bus_write_data[15:0];
            bus_pkg::ls_word: wr_word = bus_write_data[31:0];
            default: wr_word = step ? bus_write_data[63:32] : bus_write_data[31:0];
        endcase
    end

    // load lane pick, zero-extended
    always_comb begin
        case (size)
            bus_pkg::ls_byte:
                load_data = {{(bus_pkg::data_w - 8){1'b0}}, rd_q.bytes[lane]};
            bus_pkg::ls_half:
                load_data = {{(bus_pkg::data_w - 16){1'b0}}, rd_q.halves[lane[1]]};
            default:
                load_data = {{(bus_pkg::data_w - 32){1'b0}}, rd_q};
        endcase
    end

    // memory ports
    // write lands one cycle after the read that fed the merge
    always_ff @(posedge CLOCK_50) begin
        if (go_wr && pend) begin
            mem[wr_idx] <= wr_word;
        end
        rd_q <= mem[rd_idx];
    end

    // access sequencing
    // single word: issue, then finish
    // doubleword: issue, low step, high step
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pend          <= 1'b0;
            step          <= 1'b0;
            ram_read_ack  <= 1'b0;
            ram_write_ack <= 1'b0;
        end else begin
            ram_read_ack  <= 1'b0;
            ram_write_ack <= 1'b0;
            if (go_rd || go_wr) begin
                if (!pend) begin
                    pend <= 1'b1;
                end else if (is_double && !step) begin
                    step <= 1'b1;
                end else begin
                    pend          <= 1'b0;
                    step          <= 1'b0;
                    ram_read_ack  <= go_rd;
                    ram_write_ack <= go_wr;
                end
            end
        end
    end

    // read data capture
    always_ff @(posedge CLOCK_50) begin
        if (go_rd && pend) begin
            if (!is_double) begin
                ram_rdata <= load_data;
            end else if (step) begin
                ram_rdata[63:32] <= rd_q;
            end else begin
                ram_rdata[31:0] <= rd_q;
            end
        end
    end

endmodule

/* src/io_regs.sv */
module io_regs (
    input  logic                       CLOCK_50,
    input  logic                       KEY0,
    input  logic [bus_pkg::addr_w-1:0] bus_address,
    input  logic [bus_pkg::data_w-1:0] bus_write_data,
    input  logic                       read_active,
    input  logic                       write_active,
    input  logic [7:0]                 key_ascii,
    input  logic                       key_pressed,
    input  logic                       interrupt_ack,
    output logic                       io_hit,
    output logic                       io_read_ack,
    output logic                       io_write_ack,
    output logic [bus_pkg::data_w-1:0] io_rdata,
    output logic [3:0]                 interrupt_vector,
    output logic [7:0]                 console_data,
    output logic                       console_write
);

    logic       key_sel;
    logic       console_sel;
    logic       key_prev;
    logic       key_edge;
    logic [7:0] key_code;
    logic       go_rd;
    logic       go_wr;

    // register decode
    assign key_sel     = bus_address == soc_map_pkg::key_addr;
    assign console_sel = bus_address == soc_map_pkg::console_addr;
    assign io_hit      = key_sel || console_sel;

    // one-cycle acks, same gating as the memory
    assign go_rd = read_active && io_hit && !io_read_ack;
    assign go_wr = write_active && io_hit && !io_write_ack;

    // press edge
    assign key_edge = key_pressed && !key_prev;

    // keyboard register and interrupt
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_prev         <= 1'b0;
            key_code         <= 8'd0;
            interrupt_vector <= 4'd0;
        end else begin
            key_prev <= key_pressed;
            if (key_edge) begin
                key_code <= key_ascii;
            end
            if (interrupt_ack) begin
                interrupt_vector <= 4'd0;
            end
            // later assignment, a press beats an ack in the same cycle
            if (key_edge && key_ascii != 8'd0) begin
                interrupt_vector <= soc_map_pkg::irq_key;
            end
        end
    end

    // bus side acks and console strobe
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            io_read_ack   <= 1'b0;
            io_write_ack  <= 1'b0;
            console_write <= 1'b0;
        end else begin
            io_read_ack   <= go_rd;
            io_write_ack  <= go_wr;
            // pulses together with the write ack
            console_write <= go_wr && console_sel;
        end
    end

    // payload
    // console port reads back as zero
    always_ff @(posedge CLOCK_50) begin
        if (go_rd) begin
            io_rdata <= key_sel ? {{(bus_pkg::data_w - 8){1'b0}}, key_code} : '0;
        end
        if (go_wr && console_sel) begin
            console_data <= bus_write_data[7:0];
        end
    end

endmodule

/* src/bus_responder.sv */
module bus_responder (
    input  logic                       CLOCK_50,
    input  logic                       KEY0,
    input  logic                       bus_read_enable,
    input  logic                       bus_write_enable,
    input  logic                       ram_hit,
    input  logic                       io_hit,
    input  logic                       ram_read_ack,
    input  logic                       ram_write_ack,
    input  logic                       io_read_ack,
    input  logic                       io_write_ack,
    input  logic [bus_pkg::data_w-1:0] ram_rdata,
    input  logic [bus_pkg::data_w-1:0] io_rdata,
    output logic                       read_active,
    output logic                       write_active,
    output logic [bus_pkg::data_w-1:0] bus_read_data,
    output logic                       bus_read_done,
    output logic                       bus_write_done
);

    logic miss;
    logic miss_read_ack;
    logic miss_write_ack;
    logic read_ack;
    logic write_ack;

    // window is open while done is low
    // opens the cycle after the strobe, closes the cycle after the ack
    assign read_active  = !bus_read_done;
    assign write_active = !bus_write_done;

    // nobody claims the address
    assign miss = !ram_hit && !io_hit;

    // any side finishing the access
    assign read_ack  = ram_read_ack || io_read_ack || miss_read_ack;
    assign write_ack = ram_write_ack || io_write_ack || miss_write_ack;

    // done levels and unmapped completion
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            miss_read_ack  <= 1'b0;
            miss_write_ack <= 1'b0;
        end else begin
            // unmapped access answers one cycle into the window
            miss_read_ack  <= read_active && miss && !miss_read_ack;
            miss_write_ack <= write_active && miss && !miss_write_ack;

            // strobe drops done, ack raises it again
            if (bus_read_enable) begin
                bus_read_done <= 1'b0;
            end else if (read_ack) begin
                bus_read_done <= 1'b1;
            end

            if (bus_write_enable) begin
                bus_write_done <= 1'b0;
            end else if (write_ack) begin
                bus_write_done <= 1'b1;
            end
        end
    end

    // read data from whichever side acked
    // unmapped reads return zero
    always_ff @(posedge CLOCK_50) begin
        if (ram_read_ack) begin
            bus_read_data <= ram_rdata;
        end else if (io_read_ack) begin
            bus_read_data <= io_rdata;
        end else if (miss_read_ack) begin
            bus_read_data <= '0;
        end
    end

endmodule

/* src/soc_bus_top.sv */
module soc_bus_top #(
    parameter int ram_words = 3072
) (
    input  logic                       CLOCK_50,
    input  logic                       KEY0,
    input  logic [bus_pkg::addr_w-1:0] bus_address,
    input  logic [bus_pkg::data_w-1:0] bus_write_data,
    input  bus_pkg::ls_type_t          bus_ls_type,
    input  logic                       bus_read_enable,
    input  logic                       bus_write_enable,
    output logic [bus_pkg::data_w-1:0] bus_read_data,
    output logic                       bus_read_done,
    output logic                       bus_write_done,
    input  logic [7:0]                 key_ascii,
    input  logic                       key_pressed,
    input  logic                       interrupt_ack,
    output logic [3:0]                 interrupt_vector,
    output logic [7:0]                 console_data,
    output logic                       console_write
);

    // access windows from the responder
    logic read_active;
    logic write_active;

    // memory side
    logic                       ram_hit;
    logic                       ram_read_ack;
    logic                       ram_write_ack;
    logic [bus_pkg::data_w-1:0] ram_rdata;

    // io side
    logic                       io_hit;
    logic                       io_read_ack;
    logic                       io_write_ack;
    logic [bus_pkg::data_w-1:0] io_rdata;

    // data memory, depth set here
    data_ram #(
        .ram_words(ram_words)
    ) u_data_ram (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .bus_address   (bus_address),
        .bus_write_data(bus_write_data),
        .bus_ls_type   (bus_ls_type),
        .read_active   (read_active),
        .write_active  (write_active),
        .ram_hit       (ram_hit),
        .ram_read_ack  (ram_read_ack),
        .ram_write_ack (ram_write_ack),
        .ram_rdata     (ram_rdata)
    );

    // keyboard, interrupt, console
    io_regs u_io_regs (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .bus_address     (bus_address),
        .bus_write_data  (bus_write_data),
        .read_active     (read_active),
        .write_active    (write_active),
        .key_ascii       (key_ascii),
        .key_pressed     (key_pressed),
        .interrupt_ack   (interrupt_ack),
        .io_hit          (io_hit),
        .io_read_ack     (io_read_ack),
        .io_write_ack    (io_write_ack),
        .io_rdata        (io_rdata),
        .interrupt_vector(interrupt_vector),
        .console_data    (console_data),
        .console_write   (console_write)
    );

    // done levels and read data back to the core
    bus_responder u_bus_responder (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .bus_read_enable (bus_read_enable),
        .bus_write_enable(bus_write_enable),
        .ram_hit         (ram_hit),
        .io_hit          (io_hit),
        .ram_read_ack    (ram_read_ack),
        .ram_write_ack   (ram_write_ack),
        .io_read_ack     (io_read_ack),
        .io_write_ack    (io_write_ack),
        .ram_rdata       (ram_rdata),
        .io_rdata        (io_rdata),
        .read_active     (read_active),
        .write_active    (write_active),
        .bus_read_data   (bus_read_data),
        .bus_read_done   (bus_read_done),
        .bus_write_done  (bus_write_done)
    );

endmodule

/* sim/tb_tasks.svh */
task automatic check_value(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
    if (actual !== expected) begin
        error_count++;
        $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
        $display(">>> FAIL");
        $fatal(1, "stopped at first mismatch");
    end
endtask

// memory window is base plus four bytes per word
function automatic bit in_ram(input logic [63:0] addr);
    return addr >= soc_map_pkg::ram_base && addr < soc_map_pkg::ram_base + 64'(4 * ram_words);
endfunction

function automatic int word_index(input logic [63:0] addr);
    return int'((addr - soc_map_pkg::ram_base) >> 2);
endfunction

function automatic logic [63:0] word_addr(input int idx);
    return soc_map_pkg::ram_base + 64'(idx) * 64'd4;
endfunction

// ack latency in cycles by target
function automatic int expected_latency(input logic [63:0] addr, input bus_pkg::ls_type_t ls);
    if (in_ram(addr)) begin
        return (ls[1:0] == bus_pkg::ls_double) ? 3 : 2;
    end
    return 1;
endfunction

// addressed lane from the model zero-extended
function automatic logic [63:0] expected_load(input logic [63:0] addr,
                                              input bus_pkg::ls_type_t ls);
    int          idx;
    int          lane;
    logic [31:0] word;
    logic [63:0] result;
    idx  = word_index(addr);
    lane = int'(addr[1:0]);
    word = model[idx];
    case (ls[1:0])
        bus_pkg::ls_byte: result = 64'(word[8*lane +: 8]);
        bus_pkg::ls_half: result = 64'(word[8*lane +: 16]);
        bus_pkg::ls_word: result = 64'(word);
        default:          result = {model[idx + 1], word};
    endcase
    return result;
endfunction

// one strobe and a wait on done
// ack_at counts edges from the done drop to the first ack
task automatic bus_access(input bit write, input logic [63:0] addr, input logic [63:0] wdata,
                          input bus_pkg::ls_type_t ls, output logic [63:0] rdata,
                          output int ack_at);
    int   cycles;
    logic ack_now;
    logic done_now;
    @(posedge CLOCK_50);
    bus_address      <= addr;
    bus_write_data   <= wdata;
    bus_ls_type      <= ls;
    bus_write_enable <= write;
    bus_read_enable  <= !write;
    @(posedge CLOCK_50);
    bus_write_enable <= 1'b0;
    bus_read_enable  <= 1'b0;
    @(negedge CLOCK_50);
    // done drops at the strobe edge
    if (write) begin
        check_value("bus_write_done", 64'(bus_write_done), 64'd0);
    end else begin
        check_value("bus_read_done", 64'(bus_read_done), 64'd0);
    end
    cycles         = 0;
    ack_at         = 0;
    console_pulses = 0;
    done_now       = 1'b0;
    while (!done_now) begin
        @(negedge CLOCK_50);
        cycles++;
        if (write) begin
            ack_now  = dut.ram_write_ack || dut.io_write_ack || dut.u_bus_responder.miss_write_ack;
            done_now = bus_write_done;
        end else begin
            ack_now  = dut.ram_read_ack || dut.io_read_ack || dut.u_bus_responder.miss_read_ack;
            done_now = bus_read_done;
        end
        if (ack_now && ack_at == 0) begin
            ack_at = cycles;
        end
        if (console_write) begin
            console_pulses++;
            console_seen = console_data;
        end
    end
    rdata = bus_read_data;
endtask

// store and fold it into the model by size
task automatic store(input logic [63:0] addr, input logic [63:0] data,
                     input bus_pkg::ls_type_t ls);
    logic [63:0] rdata;
    int          ack_at;
    int          idx;
    int          lane;
    logic [31:0] word;
    bus_access(1'b1, addr, data, ls, rdata, ack_at);
    check_value("write ack latency", 64'(ack_at), 64'(expected_latency(addr, ls)));
    if (in_ram(addr)) begin
        idx  = word_index(addr);
        lane = int'(addr[1:0]);
        word = model.exists(idx) ? model[idx] : 32'h0;
        case (ls[1:0])
            bus_pkg::ls_byte: word[8*lane +: 8] = data[7:0];
            bus_pkg::ls_half: word[8*lane +: 16] = data[15:0];
            default:          word = data[31:0];
        endcase
        model[idx] = word;
        // high word one word up
        if (ls[1:0] == bus_pkg::ls_double) begin
            model[idx + 1] = data[63:32];
        end
    end
endtask

task automatic load_check(input logic [63:0] addr, input bus_pkg::ls_type_t ls,
                          input logic [63:0] expected);
    logic [63:0] rdata;
    int          ack_at;
    bus_access(1'b0, addr, 64'd0, ls, rdata, ack_at);
    check_value("read ack latency", 64'(ack_at), 64'(expected_latency(addr, ls)));
    check_value("bus_read_data", rdata, expected);
endtask

// press and/or ack for one cycle each
task automatic key_event(input bit press, input logic [7:0] code, input bit ack);
    @(posedge CLOCK_50);
    key_ascii     <= code;
    key_pressed   <= press;
    interrupt_ack <= ack;
    @(posedge CLOCK_50);
    key_pressed   <= 1'b0;
    interrupt_ack <= 1'b0;
    @(negedge CLOCK_50);
endtask

task automatic test_reset_state();
    @(negedge CLOCK_50);
    check_value("bus_read_done", 64'(bus_read_done), 64'd1);
    check_value("bus_write_done", 64'(bus_write_done), 64'd1);
    check_value("interrupt_vector", 64'(interrupt_vector), 64'd0);
    check_value("console_write", 64'(console_write), 64'd0);
endtask

task automatic test_word_round_trip();
    int idx [8];
    for (int i = 0; i < 8; i++) begin
        idx[i] = $urandom % ram_words;
        store(word_addr(idx[i]), {$urandom, $urandom}, {1'b0, bus_pkg::ls_word});
    end
    for (int i = 0; i < 8; i++) begin
        load_check(word_addr(idx[i]), {1'b0, bus_pkg::ls_word},
                   expected_load(word_addr(idx[i]), {1'b0, bus_pkg::ls_word}));
    end
endtask

task automatic test_lane_access();
    logic [63:0] base;
    int          lane;
    base = word_addr($urandom % ram_words);
    // every lane has its top bit set
    store(base, 64'hffff_0000_8cf1_a7d3, {1'b0, bus_pkg::ls_word});
    // merged lanes keep their top bit set too
    lane = $urandom % 4;
    store(base + 64'(lane), {$urandom, $urandom} | 64'h80, {1'b0, bus_pkg::ls_byte});
    lane = 2 * ($urandom % 2);
    store(base + 64'(lane), {$urandom, $urandom} | 64'h8080, {1'b0, bus_pkg::ls_half});
    load_check(base, {1'b0, bus_pkg::ls_word}, expected_load(base, {1'b0, bus_pkg::ls_word}));
    // each lane with the unsigned bit clear and set
    for (int i = 0; i < 4; i++) begin
        for (int u = 0; u < 2; u++) begin
            load_check(base + 64'(i), {u[0], bus_pkg::ls_byte},
                       expected_load(base + 64'(i), {u[0], bus_pkg::ls_byte}));
        end
    end
    for (int i = 0; i < 2; i++) begin
        for (int u = 0; u < 2; u++) begin
            load_check(base + 64'(2 * i), {u[0], bus_pkg::ls_half},
                       expected_load(base + 64'(2 * i), {u[0], bus_pkg::ls_half}));
        end
    end
endtask

task automatic test_doubleword();
    logic [63:0] addr;
    for (int rep = 0; rep < 2; rep++) begin
        addr = word_addr(2 * ($urandom % (ram_words / 2)));
        store(addr, {$urandom, $urandom}, {1'b0, bus_pkg::ls_double});
        load_check(addr, {1'b0, bus_pkg::ls_double},
                   expected_load(addr, {1'b0, bus_pkg::ls_double}));
        load_check(addr, {1'b0, bus_pkg::ls_word}, expected_load(addr, {1'b0, bus_pkg::ls_word}));
        load_check(addr + 64'd4, {1'b0, bus_pkg::ls_word},
                   expected_load(addr + 64'd4, {1'b0, bus_pkg::ls_word}));
    end
endtask

task automatic test_keyboard();
    logic [31:0] r;
    logic [7:0]  code;
    r    = $urandom;
    // printable and never zero
    code = 8'(32 + r % 95);
    key_event(1'b1, code, 1'b0);
    check_value("interrupt_vector", 64'(interrupt_vector), 64'd1);
    load_check(soc_map_pkg::key_addr, {1'b0, bus_pkg::ls_word}, 64'(code));
    key_event(1'b0, 8'd0, 1'b1);
    check_value("interrupt_vector", 64'(interrupt_vector), 64'd0);
    // press and ack together and the press wins
    key_event(1'b1, code, 1'b1);
    check_value("interrupt_vector", 64'(interrupt_vector), 64'd1);
    key_event(1'b0, 8'd0, 1'b1);
    check_value("interrupt_vector", 64'(interrupt_vector), 64'd0);
    key_event(1'b1, 8'd0, 1'b0);
    check_value("interrupt_vector", 64'(interrupt_vector), 64'd0);
endtask

task automatic test_console_and_unmapped();
    logic [63:0] data;
    logic [63:0] addr;
    data = {$urandom, $urandom};
    store(soc_map_pkg::console_addr, data, {1'b0, bus_pkg::ls_word});
    check_value("console_write pulses", 64'(console_pulses), 64'd1);
    check_value("console_data", 64'(console_seen), 64'(data[7:0]));
    @(negedge CLOCK_50);
    check_value("console_write", 64'(console_write), 64'd0);
    // far above both windows
    addr = 64'h8000_0000_0000_0000 | (64'($urandom) << 3);
    load_check(addr, {1'b0, bus_pkg::ls_double}, 64'd0);
endtask

/* sim/tb_soc_bus.sv */
module tb_soc_bus;

    localparam int reset_cycles = 5;
    localparam int ram_words    = 3072;
    // bus accesses issued by the directed tests
    localparam int n_accesses   = 43;
    localparam int cycle_limit  = 40 * n_accesses + reset_cycles;

    logic                       CLOCK_50;
    logic                       KEY0;
    logic [bus_pkg::addr_w-1:0] bus_address;
    logic [bus_pkg::data_w-1:0] bus_write_data;
    bus_pkg::ls_type_t          bus_ls_type;
    logic                       bus_read_enable;
    logic                       bus_write_enable;
    logic [bus_pkg::data_w-1:0] bus_read_data;
    logic                       bus_read_done;
    logic                       bus_write_done;
    logic [7:0]                 key_ascii;
    logic                       key_pressed;
    logic                       interrupt_ack;
    logic [3:0]                 interrupt_vector;
    logic [7:0]                 console_data;
    logic                       console_write;

    int cycle_count = 0;
    int error_count = 0;
    // console strobes seen during the last access
    int         console_pulses;
    logic [7:0] console_seen;
    // expected memory words keyed by word index
    logic [31:0] model [int];

    // port names match the local signals
    soc_bus_top #(
        .ram_words(ram_words)
    ) dut (.*);

    `include "tb_tasks.svh"

    initial begin
        CLOCK_50 = 1'b0;
        forever #5 CLOCK_50 = ~CLOCK_50;
    end

    // hard stop if an access never completes
    always @(posedge CLOCK_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: no end of test after %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $fatal(1, "run limit reached");
        end
    end

    initial begin
        void'($urandom(90322));
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_ls_type      = '0;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        key_ascii        = 8'd0;
        key_pressed      = 1'b0;
        interrupt_ack    = 1'b0;
        repeat (reset_cycles) @(posedge CLOCK_50);
        KEY0 <= 1'b1;

        test_reset_state();
        test_word_round_trip();
        test_lane_access();
        test_doubleword();
        test_keyboard();
        test_console_and_unmapped();

        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+sim
src/bus_pkg.sv
src/soc_map_pkg.sv
src/data_ram.sv
src/io_regs.sv
src/bus_responder.sv
src/soc_bus_top.sv
sim/tb_soc_bus.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_soc_bus
FILELIST = verilog.f

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '>>> PASS'

clean:
	rm -rf obj_dir
